// File: Makefile
# Verilator build and run of the audio peripheral testbench

VERILATOR ?= verilator
TOP       ?= audio_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/audio_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, register map and envelope tables of the audio peripheral
// envelope increments assume a 1 MHz voice tick from a 16 MHz system clock
////////////////////////////////////////////////////////////////////////////

package audio_pkg;

  localparam int SAMPLE_BITS = 12;
  localparam int DAC_BITS    = 14;
  localparam int ACC_BITS    = 24;
  localparam int NUM_VOICES  = 3;
  localparam int VOICE_BITS  = 2;
  localparam int TICK_DIV    = 16;

  localparam int LFSR_BITS     = 23;
  localparam int LFSR_CLK_BIT  = 19;
  localparam logic [LFSR_BITS-1:0] LFSR_SEED = 23'b0110111_0010010_0001010_11;

  ////////////////////////////////////////////////////////////////////////////
  // register map, four words per voice
  ////////////////////////////////////////////////////////////////////////////
  localparam int REGS_PER_VOICE = 4;
  localparam logic [3:0] REG_FREQ       = 4'd0;
  localparam logic [3:0] REG_PULSEWIDTH = 4'd1;
  localparam logic [3:0] REG_WAVEPARAMS = 4'd2;
  localparam logic [3:0] REG_GATE       = 4'd3;

  // wave-params word
  localparam int BIT_ENABLE = 27;
  localparam int BIT_TEST   = 25;
  localparam int BIT_NOISE  = 19;
  localparam int BIT_PULSE  = 18;
  localparam int BIT_SAW    = 17;
  localparam int BIT_TRI    = 16;
  localparam int ATTACK_LSB  = 12;
  localparam int DECAY_LSB   = 8;
  localparam int SUSTAIN_LSB = 4;
  localparam int RELEASE_LSB = 0;

  ////////////////////////////////////////////////////////////////////////////
  // envelope
  ////////////////////////////////////////////////////////////////////////////
  localparam int ENV_ACC_BITS = 26;

  typedef enum logic [2:0] {
    ENV_IDLE,
    ENV_ATTACK,
    ENV_DECAY,
    ENV_SUSTAIN,
    ENV_RELEASE
  } env_state_t;

  // 2^26 / ramp time in us, attack 2 ms .. 8 s
  localparam logic [16:0] ATTACK_INC [16] = '{
    17'd33554, 17'd8388, 17'd4194, 17'd2796, 17'd1766, 17'd1198, 17'd986, 17'd838,
    17'd671,   17'd268,  17'd134,  17'd83,   17'd67,   17'd22,   17'd13,  17'd8
  };

  // decay and release ramps take three times as long
  localparam logic [16:0] DECAY_INC [16] = '{
    17'd11184, 17'd2796, 17'd1398, 17'd932, 17'd588, 17'd399, 17'd328, 17'd279,
    17'd223,   17'd89,   17'd44,   17'd27,  17'd22,  17'd7,   17'd4,   17'd2
  };

endpackage

// File: dv/audio_checker.sv
////////////////////////////////////////////////////////////////////////////
// bus and pdm output checker, expected values come from the testbench
// ones are counted over WINDOW clocks after each density_start pulse
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_checker #(
  parameter int WINDOW = 16384
) (
  input  logic        clk,
  input  logic        resetn,
  input  logic        iomem_valid,
  input  logic        iomem_ready,
  input  logic [31:0] iomem_rdata,
  input  logic        audio_out,
  input  logic        check_read,
  input  logic [31:0] exp_rdata,
  input  logic        density_start,
  input  int          exp_ones,
  input  int          ones_tol,
  output logic        density_done,
  output int          ready_errors,
  output int          read_errors,
  output int          density_errors
);

  logic ready_due;
  int   ones;
  int   left;

  ////////////////////////////////////////////////////////////////////////////
  // bus, ready follows a cycle with valid high and ready low
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    if (!resetn) begin
      ready_due    <= 1'b0;
      ready_errors <= 0;
      read_errors  <= 0;
    end else begin
      ready_due <= iomem_valid && !iomem_ready;
      if (iomem_ready !== ready_due) begin
        $display("Fail at %0t: iomem_ready is %b, expected %b", $time, iomem_ready, ready_due);
        ready_errors <= ready_errors + 1;
      end
      if (iomem_ready && check_read && (iomem_rdata !== exp_rdata)) begin
        $display("Fail at %0t: read data %h, expected %h", $time, iomem_rdata, exp_rdata);
        read_errors <= read_errors + 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // audio_out density
  ////////////////////////////////////////////////////////////////////////////
  always @(posedge clk) begin
    int total;
    total = ones + int'(audio_out);
    if (!resetn) begin
      left           <= 0;
      ones           <= 0;
      density_done   <= 1'b0;
      density_errors <= 0;
    end else if (density_start) begin
      left         <= WINDOW;
      ones         <= 0;
      density_done <= 1'b0;
    end else if (left != 0) begin
      ones <= total;
      left <= left - 1;
      if (left == 1) begin
        density_done <= 1'b1;
        if ((total > exp_ones + ones_tol) || (total < exp_ones - ones_tol)) begin
          $display("Fail at %0t: audio_out gave %0d ones in %0d clocks, expected %0d +/- %0d",
                   $time, total, WINDOW, exp_ones, ones_tol);
          density_errors <= density_errors + 1;
        end
      end
    end
  end

endmodule

// File: dv/audio_tb.sv
////////////////////////////////////////////////////////////////////////////
// audio peripheral testbench that drives the bus 1 ns after the rising edge
// static levels rely on the test bit and envelopes need ~130k clocks to sustain
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_tb;

  localparam int WINDOW      = 16384;
  localparam int RAND_ROUNDS = 8;
  localparam int NUM_ENTRIES = 38;

  localparam logic [1:0] K_WR  = 2'd0;
  localparam logic [1:0] K_RD  = 2'd1;
  localparam logic [1:0] K_DEN = 2'd2;

  // data is write data, expected read data or expected ones count
  typedef struct packed {
    logic [1:0]  kind;
    logic [3:0]  word;
    logic [31:0] data;
    logic [3:0]  strb;
    logic [9:0]  tol;
    logic [17:0] wait_cyc;
  } entry_t;

  logic        clk = 1'b0;
  logic        resetn;
  logic        iomem_valid;
  logic [3:0]  iomem_wstrb;
  logic [31:0] iomem_addr;
  logic [31:0] iomem_wdata;
  logic        iomem_ready;
  logic [31:0] iomem_rdata;
  logic        audio_out;

  logic        check_read;
  logic [31:0] exp_rdata;
  logic        density_start;
  int          exp_ones;
  int          ones_tol;
  logic        density_done;
  int          ready_errors;
  int          read_errors;
  int          density_errors;

  logic [31:0] shadow [16];
  logic [3:0]  rnd_word;
  logic [31:0] rnd_data;
  logic [3:0]  rnd_strb;

  ////////////////////////////////////////////////////////////////////////////
  // stimulus table
  // kind, word, data, strobes, tolerance, wait cycles after the entry
  ////////////////////////////////////////////////////////////////////////////
  entry_t stim [NUM_ENTRIES] = '{
    // voices come up disabled and gated off and the dac idles at half density
    '{K_RD,  4'd2,  32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_RD,  4'd3,  32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_RD,  4'd6,  32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_RD,  4'd7,  32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_RD,  4'd10, 32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_RD,  4'd11, 32'h0000_0000, 4'h0, 10'd0,   18'd0},
    '{K_DEN, 4'd0,  32'd8192,      4'h0, 10'd2,   18'd0},
    // full-width pulse under the test bit with voices 1 and 2 gated but muted
    '{K_WR,  4'd1,  32'h0000_0FFF, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd5,  32'h0000_0FFF, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd6,  32'h0204_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd10, 32'h0204_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd7,  32'h0000_0001, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd11, 32'h0000_0001, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd2,  32'h0A04_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd3,  32'h0000_0001, 4'hF, 10'd0,   18'd150000},
    // 2047 * 255 >> 8 is 2039 and the mix is 1019
    '{K_DEN, 4'd0,  32'd9211,      4'h0, 10'd2,   18'd0},
    // sustain 8 gives amplitude 136 and a sample of 1087
    '{K_WR,  4'd2,  32'h0A04_0080, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd8735,      4'h0, 10'd2,   18'd0},
    // saw and triangle sit at -2048 with the accumulator held at 0
    '{K_WR,  4'd2,  32'h0A02_00F0, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd7172,      4'h0, 10'd2,   18'd0},
    '{K_WR,  4'd2,  32'h0A01_00F0, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd7172,      4'h0, 10'd2,   18'd0},
    // noise from the seed is 0x700, so -256 signed and -255 scaled
    '{K_WR,  4'd2,  32'h0A08_00F0, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd8064,      4'h0, 10'd2,   18'd0},
    // 2039 + 2039 - 255 = 3823 gives a mix of 1911
    '{K_WR,  4'd2,  32'h0A04_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd6,  32'h0A04_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd10, 32'h0A08_00F0, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd10103,     4'h0, 10'd2,   18'd0},
    // running saw with one period per density window
    '{K_WR,  4'd6,  32'h0204_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd10, 32'h0208_00F0, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd0,  32'h0000_4000, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd2,  32'h0802_00F0, 4'hF, 10'd0,   18'd64},
    '{K_DEN, 4'd0,  32'd8192,      4'h0, 10'd400, 18'd0},
    // static full-scale pulse on voice 0 so a missed release shows at 9211
    '{K_WR,  4'd2,  32'h0A04_00F0, 4'hF, 10'd0,   18'd0},
    // gates off so every envelope releases to idle
    '{K_WR,  4'd3,  32'h0000_0000, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd7,  32'h0000_0000, 4'hF, 10'd0,   18'd0},
    '{K_WR,  4'd11, 32'h0000_0000, 4'hF, 10'd0,   18'd150000},
    '{K_DEN, 4'd0,  32'd8192,      4'h0, 10'd2,   18'd0}
  };

  always #20 clk = ~clk;

  audio_top u_audio_top (
    .clk         (clk),
    .resetn      (resetn),
    .iomem_valid (iomem_valid),
    .iomem_wstrb (iomem_wstrb),
    .iomem_addr  (iomem_addr),
    .iomem_wdata (iomem_wdata),
    .iomem_ready (iomem_ready),
    .iomem_rdata (iomem_rdata),
    .audio_out   (audio_out)
  );

  audio_checker #(.WINDOW(WINDOW)) u_checker (
    .clk            (clk),
    .resetn         (resetn),
    .iomem_valid    (iomem_valid),
    .iomem_ready    (iomem_ready),
    .iomem_rdata    (iomem_rdata),
    .audio_out      (audio_out),
    .check_read     (check_read),
    .exp_rdata      (exp_rdata),
    .density_start  (density_start),
    .exp_ones       (exp_ones),
    .ones_tol       (ones_tol),
    .density_done   (density_done),
    .ready_errors   (ready_errors),
    .read_errors    (read_errors),
    .density_errors (density_errors)
  );

  // one access held until ready, then a cycle for the checker to compare
  task automatic bus_access(input logic [3:0] word, input logic [31:0] data,
                            input logic [3:0] strb, input logic check,
                            input logic [31:0] expected);
    @(posedge clk);
    #1;
    iomem_valid = 1'b1;
    iomem_addr  = {26'd0, word, 2'b00};
    iomem_wdata = data;
    iomem_wstrb = strb;
    check_read  = check;
    exp_rdata   = expected;
    @(posedge clk);
    #1;
    while (!iomem_ready) begin
      @(posedge clk);
      #1;
    end
    iomem_valid = 1'b0;
    @(posedge clk);
    #1;
    check_read = 1'b0;
  endtask

  task automatic measure_density(input int expected, input int tol);
    @(posedge clk);
    #1;
    exp_ones      = expected;
    ones_tol      = tol;
    density_start = 1'b1;
    @(posedge clk);
    #1;
    density_start = 1'b0;
    while (!density_done) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic apply_entry(input entry_t e);
    case (e.kind)
      K_WR:    bus_access(e.word, e.data, e.strb, 1'b0, 32'h0);
      K_RD:    bus_access(e.word, 32'h0, 4'h0, 1'b1, e.data);
      default: measure_density(int'(e.data), int'(e.tol));
    endcase
    repeat (e.wait_cyc) @(posedge clk);
  endtask

  // words 12 to 15 belong to no voice, so random data there is harmless
  task automatic random_bus_rounds();
    for (int w = 12; w < 16; w++) begin
      shadow[w] = $urandom;
      bus_access(4'(w), shadow[w], 4'hF, 1'b0, 32'h0);
    end
    for (int n = 0; n < RAND_ROUNDS; n++) begin
      rnd_word = 4'(12 + $urandom_range(3));
      rnd_data = $urandom;
      rnd_strb = 4'($urandom);
      // read data shows the word before the write
      bus_access(rnd_word, rnd_data, rnd_strb, 1'b1, shadow[rnd_word]);
      for (int b = 0; b < 4; b++) begin
        if (rnd_strb[b]) begin
          shadow[rnd_word][8*b +: 8] = rnd_data[8*b +: 8];
        end
      end
      bus_access(rnd_word, 32'h0, 4'h0, 1'b1, shadow[rnd_word]);
    end
  endtask

  function automatic longint run_cycles();
    longint total;
    total = 5 + 4 * 4 + RAND_ROUNDS * 8;
    foreach (stim[i]) begin
      total += stim[i].wait_cyc + ((stim[i].kind == K_DEN) ? WINDOW + 4 : 4);
    end
    return total;
  endfunction

  task automatic report_counts();
    $display("errors: ready %0d, read %0d, density %0d",
             ready_errors, read_errors, density_errors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////
  initial begin
    resetn        = 1'b0;
    iomem_valid   = 1'b0;
    iomem_wstrb   = 4'h0;
    iomem_addr    = 32'h0;
    iomem_wdata   = 32'h0;
    check_read    = 1'b0;
    exp_rdata     = 32'h0;
    density_start = 1'b0;
    exp_ones      = 0;
    ones_tol      = 0;
    void'($urandom(32'h9205));
    repeat (5) @(posedge clk);
    #1;
    resetn = 1'b1;
    random_bus_rounds();
    foreach (stim[i]) begin
      apply_entry(stim[i]);
    end
    report_counts();
    if (ready_errors + read_errors + density_errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    longint budget;
    budget = run_cycles();
    budget = budget + budget / 10;
    repeat (budget) @(posedge clk);
    $display("timeout: run did not finish within %0d clock cycles", budget);
    report_counts();
    $display("test failed");
    $finish;
  end

endmodule

// File: rtl/audio_output.sv
////////////////////////////////////////////////////////////////////////////
// envelope scaling, voice mix and first-order pdm dac
// the latched mix is half the sum of the scaled voices
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_output (
  input  logic                                     clk,
  input  logic                                     resetn,
  input  logic signed [audio_pkg::SAMPLE_BITS-1:0] voice_sample,
  input  logic [7:0]                               amplitude,
  input  logic                                     voice_valid,
  input  logic                                     mix_latch,
  output logic                                     audio_out
);
  import audio_pkg::*;

  logic signed [SAMPLE_BITS+8:0] product;
  logic signed [SAMPLE_BITS-1:0] scaled;
  logic signed [DAC_BITS:0]      sum;
  logic signed [DAC_BITS-1:0]    mix;
  logic [DAC_BITS-1:0]           dac_acc;
  logic [DAC_BITS-1:0]           dac_in;

  // amplitude is unsigned, so give it a zero sign bit
  assign product = voice_sample * $signed({1'b0, amplitude});
  assign scaled  = product[SAMPLE_BITS+7:8];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      sum <= '0;
      mix <= '0;
    end else if (mix_latch) begin
      mix <= sum[DAC_BITS:1];
      sum <= '0;
    end else if (voice_valid) begin
      sum <= sum + scaled;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // pdm dac, ones density follows mix + 8192
  ////////////////////////////////////////////////////////////////////////////
  assign dac_in = {~mix[DAC_BITS-1], mix[DAC_BITS-2:0]};

  always_ff @(posedge clk) begin
    if (!resetn) begin
      dac_acc   <= '0;
      audio_out <= 1'b0;
    end else begin
      {audio_out, dac_acc} <= {1'b0, dac_acc} + {1'b0, dac_in};
    end
  end

endmodule

// File: rtl/audio_regs.sv
////////////////////////////////////////////////////////////////////////////
// 16-word config bank, word select is addr[5:2]
// read data is the word as it was before a write in the same access
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_regs (
  input  logic                              clk,
  input  logic                              resetn,
  input  logic                              iomem_valid,
  input  logic [3:0]                        iomem_wstrb,
  input  logic [31:0]                       iomem_addr,
  input  logic [31:0]                       iomem_wdata,
  output logic                              iomem_ready,
  output logic [31:0]                       iomem_rdata,
  input  logic [audio_pkg::VOICE_BITS-1:0]  voice_num,
  output logic [audio_pkg::ACC_BITS-1:0]    freq_inc,
  output logic [audio_pkg::SAMPLE_BITS-1:0] pulse_width,
  output logic [31:0]                       wave_params,
  output logic                              gate
);
  import audio_pkg::*;

  logic [31:0] bank [16];
  logic [3:0]  word_sel;
  logic [3:0]  voice_base;
  logic        access;

  assign word_sel = iomem_addr[5:2];
  // ready goes high for exactly one cycle per access
  assign access   = iomem_valid && !iomem_ready;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      iomem_ready <= 1'b0;
      // voices come up disabled and gated off
      for (int v = 0; v < NUM_VOICES; v++) begin
        bank[v * REGS_PER_VOICE + REG_WAVEPARAMS] <= '0;
        bank[v * REGS_PER_VOICE + REG_GATE]       <= '0;
      end
    end else begin
      iomem_ready <= access;
      if (access) begin
        iomem_rdata <= bank[word_sel];
        for (int b = 0; b < 4; b++) begin
          if (iomem_wstrb[b]) begin
            bank[word_sel][8*b +: 8] <= iomem_wdata[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // fields of the voice the engine is working on
  ////////////////////////////////////////////////////////////////////////////
  assign voice_base  = 4'(voice_num * REGS_PER_VOICE);
  assign freq_inc    = bank[voice_base + REG_FREQ][ACC_BITS-1:0];
  assign pulse_width = bank[voice_base + REG_PULSEWIDTH][SAMPLE_BITS-1:0];
  assign wave_params = bank[voice_base + REG_WAVEPARAMS];
  assign gate        = bank[voice_base + REG_GATE][0];

endmodule

// File: rtl/audio_top.sv
////////////////////////////////////////////////////////////////////////////
// audio peripheral top, three voices mixed onto one pdm output pin
// bus accesses complete in one cycle, the master holds valid until ready
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module audio_top (
  input  logic        clk,
  input  logic        resetn,
  input  logic        iomem_valid,
  input  logic [3:0]  iomem_wstrb,
  input  logic [31:0] iomem_addr,
  input  logic [31:0] iomem_wdata,
  output logic        iomem_ready,
  output logic [31:0] iomem_rdata,
  output logic        audio_out
);
  import audio_pkg::*;

  logic [VOICE_BITS-1:0]         voice_num;
  logic [ACC_BITS-1:0]           freq_inc;
  logic [SAMPLE_BITS-1:0]        pulse_width;
  logic [31:0]                   wave_params;
  logic                          gate;
  logic signed [SAMPLE_BITS-1:0] voice_sample;
  logic [7:0]                    amplitude;
  logic                          voice_valid;
  logic                          mix_latch;

  audio_regs u_regs (
    .clk         (clk),
    .resetn      (resetn),
    .iomem_valid (iomem_valid),
    .iomem_wstrb (iomem_wstrb),
    .iomem_addr  (iomem_addr),
    .iomem_wdata (iomem_wdata),
    .iomem_ready (iomem_ready),
    .iomem_rdata (iomem_rdata),
    .voice_num   (voice_num),
    .freq_inc    (freq_inc),
    .pulse_width (pulse_width),
    .wave_params (wave_params),
    .gate        (gate)
  );

  voice_engine u_voice (
    .clk          (clk),
    .resetn       (resetn),
    .freq_inc     (freq_inc),
    .pulse_width  (pulse_width),
    .wave_params  (wave_params),
    .gate         (gate),
    .voice_num    (voice_num),
    .voice_sample (voice_sample),
    .amplitude    (amplitude),
    .voice_valid  (voice_valid),
    .mix_latch    (mix_latch)
  );

  audio_output u_out (
    .clk          (clk),
    .resetn       (resetn),
    .voice_sample (voice_sample),
    .amplitude    (amplitude),
    .voice_valid  (voice_valid),
    .mix_latch    (mix_latch),
    .audio_out    (audio_out)
  );

endmodule

// File: verilog.f
common/audio_pkg.sv
rtl/audio_regs.sv
voice/adsr_envelope.sv
voice/voice_engine.sv
rtl/audio_output.sv
rtl/audio_top.sv
dv/audio_checker.sv
dv/audio_tb.sv

// File: voice/adsr_envelope.sv
////////////////////////////////////////////////////////////////////////////
// per-voice adsr, stepped once per voice tick
// decay and release are linear ramps, amplitude lags state by one tick
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module adsr_envelope (
  input  logic                             clk,
  input  logic                             resetn,
  input  logic                             env_step,
  input  logic [audio_pkg::VOICE_BITS-1:0] voice_num,
  input  logic                             gate,
  input  logic [3:0]                       attack,
  input  logic [3:0]                       decay,
  input  logic [3:0]                       sustain,
  input  logic [3:0]                       release_rate,
  output logic [7:0]                       amplitude
);
  import audio_pkg::*;

  env_state_t            state     [NUM_VOICES];
  logic [ENV_ACC_BITS:0] env_acc   [NUM_VOICES];
  logic [7:0]            amp       [NUM_VOICES];
  logic                  prev_gate [NUM_VOICES];

  env_state_t            cur_state;
  logic [ENV_ACC_BITS:0] cur_acc;
  logic [16:0]           inc;
  logic [7:0]            ramp;
  logic [7:0]            sus_level;
  logic [7:0]            sus_gap;
  logic [15:0]           decay_drop;
  logic [15:0]           release_drop;

  assign cur_state = state[voice_num];
  assign cur_acc   = env_acc[voice_num];
  assign amplitude = amp[voice_num];

  assign inc = (cur_state == ENV_ATTACK)  ? ATTACK_INC[attack] :
               (cur_state == ENV_RELEASE) ? DECAY_INC[release_rate] : DECAY_INC[decay];

  // ramp position, 0 at the start of a phase
  assign ramp      = cur_acc[ENV_ACC_BITS-1 -: 8];
  assign sus_level = {sustain, sustain};
  assign sus_gap   = 8'd255 - sus_level;

  assign decay_drop   = ramp * sus_gap;
  assign release_drop = ramp * sus_level;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int v = 0; v < NUM_VOICES; v++) begin
        state[v]     <= ENV_IDLE;
        env_acc[v]   <= '0;
        amp[v]       <= '0;
        prev_gate[v] <= 1'b0;
      end
    end else if (env_step) begin
      prev_gate[voice_num] <= gate;
      if (gate && !prev_gate[voice_num]) begin
        state[voice_num]   <= ENV_ATTACK;
        env_acc[voice_num] <= '0;
      end else if (!gate && (cur_state inside {ENV_ATTACK, ENV_DECAY, ENV_SUSTAIN})) begin
        state[voice_num]   <= ENV_RELEASE;
        env_acc[voice_num] <= '0;
      end else if (cur_acc[ENV_ACC_BITS]) begin
        // end of a ramp
        env_acc[voice_num] <= '0;
        case (cur_state)
          ENV_ATTACK:  state[voice_num] <= ENV_DECAY;
          ENV_DECAY:   state[voice_num] <= ENV_SUSTAIN;
          ENV_RELEASE: state[voice_num] <= ENV_IDLE;
          default:     state[voice_num] <= cur_state;
        endcase
      end else begin
        case (cur_state)
          ENV_ATTACK: begin
            env_acc[voice_num] <= cur_acc + inc;
            amp[voice_num]     <= ramp;
          end
          ENV_DECAY: begin
            env_acc[voice_num] <= cur_acc + inc;
            amp[voice_num]     <= 8'd255 - decay_drop[15:8];
          end
          ENV_SUSTAIN: amp[voice_num] <= sus_level;
          ENV_RELEASE: begin
            env_acc[voice_num] <= cur_acc + inc;
            amp[voice_num]     <= sus_level - release_drop[15:8];
          end
          default: amp[voice_num] <= '0;
        endcase
      end
    end
  end

endmodule

// File: voice/voice_engine.sv
////////////////////////////////////////////////////////////////////////////
// time-shared oscillators, one voice per clock on the first three clocks
// of every 1 MHz tick, mix latch on the fourth
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module voice_engine (
  input  logic                                     clk,
  input  logic                                     resetn,
  input  logic [audio_pkg::ACC_BITS-1:0]           freq_inc,
  input  logic [audio_pkg::SAMPLE_BITS-1:0]        pulse_width,
  input  logic [31:0]                              wave_params,
  input  logic                                     gate,
  output logic [audio_pkg::VOICE_BITS-1:0]         voice_num,
  output logic signed [audio_pkg::SAMPLE_BITS-1:0] voice_sample,
  output logic [7:0]                               amplitude,
  output logic                                     voice_valid,
  output logic                                     mix_latch
);
  import audio_pkg::*;

  logic [$clog2(TICK_DIV)-1:0] tick_cnt;
  logic                        voice_step;

  logic [ACC_BITS-1:0]  acc  [NUM_VOICES];
  logic [LFSR_BITS-1:0] lfsr [NUM_VOICES];
  logic [ACC_BITS-1:0]  cur_acc;
  logic [LFSR_BITS-1:0] cur_lfsr;
  logic                 test;

  logic [SAMPLE_BITS-1:0] tri_wave;
  logic [SAMPLE_BITS-1:0] saw_wave;
  logic [SAMPLE_BITS-1:0] pulse_wave;
  logic [SAMPLE_BITS-1:0] noise_wave;
  logic [SAMPLE_BITS-1:0] combined;

  ////////////////////////////////////////////////////////////////////////////
  // tick counter and sequencer
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!resetn) begin
      tick_cnt <= '0;
    end else if (tick_cnt == TICK_DIV - 1) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // steps 0..2 are the voices, step 3 latches the mix, the rest idle
  assign voice_step  = tick_cnt < NUM_VOICES;
  assign mix_latch   = tick_cnt == NUM_VOICES;
  assign voice_num   = voice_step ? tick_cnt[VOICE_BITS-1:0] : '0;
  assign voice_valid = voice_step && wave_params[BIT_ENABLE];

  ////////////////////////////////////////////////////////////////////////////
  // phase accumulators and noise
  ////////////////////////////////////////////////////////////////////////////
  assign cur_acc  = acc[voice_num];
  assign cur_lfsr = lfsr[voice_num];
  assign test     = wave_params[BIT_TEST];

  always_ff @(posedge clk) begin
    if (!resetn) begin
      for (int v = 0; v < NUM_VOICES; v++) begin
        acc[v]  <= '0;
        lfsr[v] <= LFSR_SEED;
      end
    end else if (voice_step) begin
      if (test) begin
        // test bit parks the oscillator
        acc[voice_num]  <= '0;
        lfsr[voice_num] <= LFSR_SEED;
      end else begin
        acc[voice_num] <= cur_acc + freq_inc;
        if (cur_acc[LFSR_CLK_BIT]) begin
          lfsr[voice_num] <= {cur_lfsr[LFSR_BITS-2:0], cur_lfsr[22] ^ cur_lfsr[17]};
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // waveforms
  ////////////////////////////////////////////////////////////////////////////
  assign tri_wave   = cur_acc[ACC_BITS-1] ? ~cur_acc[ACC_BITS-2 -: SAMPLE_BITS]
                                          :  cur_acc[ACC_BITS-2 -: SAMPLE_BITS];
  assign saw_wave   = cur_acc[ACC_BITS-1 -: SAMPLE_BITS];
  assign pulse_wave = (saw_wave <= pulse_width) ? '1 : '0;
  assign noise_wave = {cur_lfsr[22], cur_lfsr[20], cur_lfsr[16], cur_lfsr[13],
                       cur_lfsr[11], cur_lfsr[7], cur_lfsr[4], cur_lfsr[2],
                       {(SAMPLE_BITS-8){1'b0}}};

  // unselected waves pass all ones through the AND
  assign combined = (wave_params[BIT_NOISE] ? noise_wave : '1)
                  & (wave_params[BIT_PULSE] ? pulse_wave : '1)
                  & (wave_params[BIT_SAW]   ? saw_wave   : '1)
                  & (wave_params[BIT_TRI]   ? tri_wave   : '1);

  // offset binary to two's complement
  assign voice_sample = {~combined[SAMPLE_BITS-1], combined[SAMPLE_BITS-2:0]};

  adsr_envelope u_env (
    .clk          (clk),
    .resetn       (resetn),
    .env_step     (voice_step),
    .voice_num    (voice_num),
    .gate         (gate),
    .attack       (wave_params[ATTACK_LSB +: 4]),
    .decay        (wave_params[DECAY_LSB +: 4]),
    .sustain      (wave_params[SUSTAIN_LSB +: 4]),
    .release_rate (wave_params[RELEASE_LSB +: 4]),
    .amplitude    (amplitude)
  );

endmodule
